// ==== Makefile ====
# Verilator simulation of the mmCore testbench

VERILATOR ?= verilator
TOP       ?= mmcore_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+src
src/mmcore_pkg.sv
src/mmcore_ctrl.sv
src/mmcore_regs.sv
src/mmcore_alu.sv
src/mmcore_top.sv
tb/mmcore_chk.sv
tb/mmcore_tb.sv

// ==== src/mmcore_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mmcore_config.svh"

module mmcore_alu (
    input  mmcore_pkg::aluOpT  aluOp,
    input  mmcore_pkg::wordT   bus,
    input  mmcore_pkg::wordT   ac,
    input  mmcore_pkg::wordT   cmpA1,
    input  mmcore_pkg::wordT   cmpA2,
    output mmcore_pkg::wordT   aluResult,
    output logic               zero
);
    import mmcore_pkg::*;

    wordT product; // Low byte of bus times AC
    wordT sum;

    assign product = bus * ac;
    assign sum     = bus + ac; // Wraps modulo 256

    always_comb begin
        case (aluOp)
            ALU_SET: aluResult = bus;
            ALU_MUL: aluResult = product;
            ALU_ADD: aluResult = sum;
            default: aluResult = ac; // Hold
        endcase
    end

    // Equal pair means the loop bound is reached
    assign zero = (cmpA1 == cmpA2);

endmodule

`default_nettype wire

// ==== src/mmcore_config.svh ====
`ifndef MMCORE_CONFIG_SVH
`define MMCORE_CONFIG_SVH

// Data word, instruction byte and memory address
`define MMCORE_WORD_W 8
`define MMCORE_PC_W   8

// Opcode field above the variant field
`define MMCORE_OP_HI  7
`define MMCORE_OP_LO  4
`define MMCORE_SUB_HI 3
`define MMCORE_SUB_LO 0

`define MMCORE_RESET_PC 0

`endif

// ==== src/mmcore_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mmcore_config.svh"

module mmcore_ctrl (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                zero,
    input  mmcore_pkg::wordT    ir,
    output logic                iromRead,
    output logic                memRead,
    output logic                memWrite,
    output logic                done,
    output logic                selAr,
    output mmcore_pkg::regEnT   regEn,
    output mmcore_pkg::incT     inc,
    output mmcore_pkg::clrT     clr,
    output mmcore_pkg::busSrcT  busSel,
    output mmcore_pkg::aluOpT   aluOp,
    output mmcore_pkg::cmpSelT  cmpSel
);
    import mmcore_pkg::*;

    stateT  state;
    stateT  stateNext;
    opcodeT op;
    logic [`MMCORE_SUB_HI-`MMCORE_SUB_LO:0] sub;

    assign op  = opcodeT'(ir[`MMCORE_OP_HI:`MMCORE_OP_LO]);
    assign sub = ir[`MMCORE_SUB_HI:`MMCORE_SUB_LO];

    // First execute state of an instruction
    function automatic stateT decodeIr(input opcodeT opc,
                                       input logic [`MMCORE_SUB_HI-`MMCORE_SUB_LO:0] v);
        stateT s;
        s = ST_NOOP;
        case (opc)
            OP_JMP:    s = (v == 4'd0) ? ST_JMP_M : (v == 4'd1) ? ST_JMP_K :
                           (v == 4'd2) ? ST_JMP_N : ST_NOOP;
            OP_COPY:   s = ST_COPY_1;
            OP_LOAD:   s = (v == 4'd0) ? ST_LOAD_C1 : (v == 4'd1) ? ST_LOAD_C2 : ST_NOOP;
            OP_STORE:  s = ST_STORE_1;
            OP_ASSIGN: s = ST_ASSIGN_1;
            OP_RESET:  s = (v == 4'd0) ? ST_RESET_ALL : (v == 4'd1) ? ST_RESET_N2 :
                           (v == 4'd2) ? ST_RESET_K2 : ST_NOOP;
            OP_MOVE:   s = (v == 4'd0) ? ST_MOVE_P : (v == 4'd1) ? ST_MOVE_T :
                           (v == 4'd2) ? ST_MOVE_C1 : ST_NOOP;
            OP_SET:    s = (v == 4'd0) ? ST_SET_C1 : (v == 4'd1) ? ST_SET_DR : ST_NOOP;
            OP_MUL:    s = ST_MUL;
            OP_ADD:    s = (v == 4'd0) ? ST_ADD_RT : (v == 4'd1) ? ST_ADD_RM1 :
                           (v == 4'd2) ? ST_ADD_RM2 : ST_NOOP;
            OP_INC: begin
                case (v)
                    4'd0:    s = ST_INC_C2;
                    4'd1:    s = ST_INC_C3;
                    4'd2:    s = ST_INC_M2;
                    4'd3:    s = ST_INC_K2;
                    4'd4:    s = ST_INC_N2;
                    default: s = ST_NOOP;
                endcase
            end
            OP_END:    s = ST_ENDOP;
            default:   s = ST_NOOP; // Unknown codes act as NOOP
        endcase
        return s;
    endfunction

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= ST_FETCH_1;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        case (state)
            ST_FETCH_1:  stateNext = ST_FETCH_2;
            ST_FETCH_2:  stateNext = ST_FETCH_3;
            ST_FETCH_3:  stateNext = decodeIr(op, sub);
            ST_JMP_M, ST_JMP_K, ST_JMP_N:
                stateNext = zero ? ST_NJMP : ST_JMP_2; // Jump while the pair differs
            ST_JMP_2:    stateNext = ST_JMP_3;
            ST_JMP_3:    stateNext = ST_JMP_4;
            ST_COPY_1:   stateNext = ST_COPY_2;
            ST_COPY_2:   stateNext = ST_COPY_3;
            ST_COPY_3:   stateNext = ST_COPY_4;
            ST_COPY_4:   stateNext = (sub == 4'd0) ? ST_COPY_M : (sub == 4'd1) ? ST_COPY_K :
                                     (sub == 4'd2) ? ST_COPY_N : ST_FETCH_1;
            ST_LOAD_C1, ST_LOAD_C2:
                stateNext = ST_LOAD_2;
            ST_LOAD_2:   stateNext = ST_LOAD_3;
            ST_STORE_1:  stateNext = ST_STORE_2;
            ST_STORE_2:  stateNext = ST_STORE_3;
            ST_ASSIGN_1: stateNext = ST_ASSIGN_2;
            ST_ASSIGN_2: stateNext = (sub == 4'd0) ? ST_ASSIGN_C1 : (sub == 4'd1) ? ST_ASSIGN_C2 :
                                     (sub == 4'd2) ? ST_ASSIGN_C3 : ST_FETCH_1;
            ST_ENDOP:    stateNext = ST_ENDOP; // Parked until reset
            default:     stateNext = ST_FETCH_1;
        endcase
    end

    // Control word is a pure decode of the current state
    always_comb begin
        iromRead = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        done     = 1'b0;
        selAr    = 1'b0;
        regEn    = '0;
        inc      = '0;
        clr      = '0;
        busSel   = BUS_MEM;
        aluOp    = ALU_NONE;
        cmpSel   = CMP_M;
        case (state)
            ST_FETCH_1, ST_JMP_2, ST_COPY_1, ST_ASSIGN_1:
                iromRead = 1'b1;
            ST_FETCH_2: begin
                regEn.ir = 1'b1;
                inc.pc   = 1'b1;
            end
            ST_JMP_K: cmpSel = CMP_K;
            ST_JMP_N: cmpSel = CMP_N;
            ST_JMP_3: begin
                regEn.ar = 1'b1; // Jump target straight from the ROM
                selAr    = 1'b1;
            end
            ST_JMP_4: begin
                regEn.pc = 1'b1;
                busSel   = BUS_AR;
            end
            ST_NJMP:  inc.pc = 1'b1; // Skip the target byte
            ST_COPY_2, ST_ASSIGN_2: begin
                regEn.ar = 1'b1;
                selAr    = 1'b1;
                inc.pc   = 1'b1;
            end
            ST_COPY_3, ST_LOAD_2:
                memRead = 1'b1;
            ST_COPY_4, ST_LOAD_3:
                regEn.dr = 1'b1; // busSel stays on MEM
            ST_COPY_M: begin
                regEn.rm1 = 1'b1;
                busSel    = BUS_DR;
            end
            ST_COPY_K: begin
                regEn.rk1 = 1'b1;
                busSel    = BUS_DR;
            end
            ST_COPY_N: begin
                regEn.rn1 = 1'b1;
                busSel    = BUS_DR;
            end
            ST_LOAD_C1: begin
                regEn.ar = 1'b1;
                busSel   = BUS_C1;
            end
            ST_LOAD_C2: begin
                regEn.ar = 1'b1;
                busSel   = BUS_C2;
            end
            ST_STORE_1: begin
                regEn.dr = 1'b1;
                busSel   = BUS_RT;
            end
            ST_STORE_2: begin
                regEn.ar = 1'b1;
                busSel   = BUS_C3;
            end
            ST_STORE_3: memWrite = 1'b1;
            ST_ASSIGN_C1: begin
                regEn.c1 = 1'b1;
                busSel   = BUS_AR;
            end
            ST_ASSIGN_C2: begin
                regEn.c2 = 1'b1;
                busSel   = BUS_AR;
            end
            ST_ASSIGN_C3: begin
                regEn.c3 = 1'b1;
                busSel   = BUS_AR;
            end
            ST_RESET_ALL: clr     = '1;
            ST_RESET_N2:  clr.rn2 = 1'b1;
            ST_RESET_K2:  clr.rk2 = 1'b1;
            ST_MOVE_P, ST_MOVE_T, ST_MOVE_C1: begin
                regEn.rp = (state == ST_MOVE_P);
                regEn.rt = (state == ST_MOVE_T);
                regEn.c1 = (state == ST_MOVE_C1);
                busSel   = BUS_AC;
            end
            ST_SET_C1, ST_SET_DR: begin
                regEn.ac = 1'b1;
                busSel   = (state == ST_SET_C1) ? BUS_C1 : BUS_DR;
                aluOp    = ALU_SET;
            end
            ST_MUL: begin
                regEn.ac = 1'b1; // AC times P
                busSel   = BUS_RP;
                aluOp    = ALU_MUL;
            end
            ST_ADD_RT, ST_ADD_RM1, ST_ADD_RM2: begin
                regEn.ac = 1'b1;
                busSel   = (state == ST_ADD_RT) ? BUS_RT :
                           (state == ST_ADD_RM1) ? BUS_RM1 : BUS_RM2;
                aluOp    = ALU_ADD;
            end
            ST_INC_C2: inc.c2  = 1'b1;
            ST_INC_C3: inc.c3  = 1'b1;
            ST_INC_M2: inc.rm2 = 1'b1;
            ST_INC_K2: inc.rk2 = 1'b1;
            ST_INC_N2: inc.rn2 = 1'b1;
            ST_ENDOP:  done    = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mmcore_pkg.sv ====
`default_nettype none

`include "mmcore_config.svh"

package mmcore_pkg;

    typedef logic [`MMCORE_WORD_W-1:0] wordT;
    typedef logic [`MMCORE_PC_W-1:0]   pcT;

    typedef enum logic [`MMCORE_OP_HI-`MMCORE_OP_LO:0] {
        OP_NOOP   = 4'h0,
        OP_JMP    = 4'h1,
        OP_COPY   = 4'h2,
        OP_LOAD   = 4'h3,
        OP_STORE  = 4'h4,
        OP_ASSIGN = 4'h5,
        OP_RESET  = 4'h6,
        OP_MOVE   = 4'h7,
        OP_SET    = 4'h8,
        OP_MUL    = 4'h9,
        OP_ADD    = 4'hA,
        OP_INC    = 4'hB, // Counter and index increments
        OP_END    = 4'hF
    } opcodeT;

    // FETCH_1 is the reset state
    typedef enum logic [5:0] {
        ST_FETCH_1, ST_FETCH_2, ST_FETCH_3,
        ST_JMP_M, ST_JMP_K, ST_JMP_N,
        ST_JMP_2, ST_JMP_3, ST_JMP_4, ST_NJMP,
        ST_COPY_1, ST_COPY_2, ST_COPY_3, ST_COPY_4,
        ST_COPY_M, ST_COPY_K, ST_COPY_N,
        ST_LOAD_C1, ST_LOAD_C2, ST_LOAD_2, ST_LOAD_3,
        ST_STORE_1, ST_STORE_2, ST_STORE_3,
        ST_ASSIGN_1, ST_ASSIGN_2,
        ST_ASSIGN_C1, ST_ASSIGN_C2, ST_ASSIGN_C3,
        ST_NOOP,
        ST_RESET_ALL, ST_RESET_N2, ST_RESET_K2,
        ST_MOVE_P, ST_MOVE_T, ST_MOVE_C1,
        ST_SET_C1, ST_SET_DR,
        ST_MUL,
        ST_ADD_RT, ST_ADD_RM1, ST_ADD_RM2,
        ST_INC_C2, ST_INC_C3, ST_INC_M2, ST_INC_K2, ST_INC_N2,
        ST_ENDOP
    } stateT;

    typedef enum logic [3:0] {
        BUS_AC  = 4'd1,  BUS_C3  = 4'd2,  BUS_C2  = 4'd3,  BUS_C1  = 4'd4,
        BUS_RN2 = 4'd5,  BUS_RK2 = 4'd6,  BUS_RM2 = 4'd7,  BUS_RN1 = 4'd8,
        BUS_RK1 = 4'd9,  BUS_RM1 = 4'd10, BUS_RT  = 4'd11, BUS_RP  = 4'd12,
        BUS_DR  = 4'd13, BUS_AR  = 4'd14, BUS_MEM = 4'd15
    } busSrcT;

    // Write enables with PC in the MSB
    typedef struct packed {
        logic pc;
        logic ir;
        logic ar;
        logic dr;
        logic rp;
        logic rt;
        logic rm1;
        logic rk1;
        logic rn1;
        logic c1;
        logic c2;
        logic c3;
        logic ac;
    } regEnT;

    typedef struct packed {
        logic pc;
        logic rm2;
        logic rk2;
        logic rn2;
        logic c2;
        logic c3;
    } incT;

    typedef struct packed {
        logic rt;
        logic rm2;
        logic rk2;
        logic rn2;
        logic ac;
    } clrT;

    typedef enum logic [1:0] {ALU_NONE, ALU_SET, ALU_MUL, ALU_ADD} aluOpT;

    typedef enum logic [1:0] {CMP_M, CMP_K, CMP_N} cmpSelT;

endpackage

`default_nettype wire

// ==== src/mmcore_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mmcore_config.svh"

module mmcore_regs (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                selAr,
    input  mmcore_pkg::regEnT   regEn,
    input  mmcore_pkg::incT     inc,
    input  mmcore_pkg::clrT     clr,
    input  mmcore_pkg::busSrcT  busSel,
    input  mmcore_pkg::wordT    iromData,
    input  mmcore_pkg::wordT    memRData,
    input  mmcore_pkg::wordT    aluResult,
    output mmcore_pkg::pcT      pc,
    output mmcore_pkg::wordT    ir,
    output mmcore_pkg::wordT    ar,
    output mmcore_pkg::wordT    dr,
    output mmcore_pkg::wordT    ac,
    output mmcore_pkg::wordT    bus,
    output mmcore_pkg::wordT    cmpA1,
    output mmcore_pkg::wordT    cmpA2,
    input  mmcore_pkg::cmpSelT  cmpSel
);
    import mmcore_pkg::*;

    wordT rp;
    wordT rt;
    wordT rm1;
    wordT rk1;
    wordT rn1;
    wordT rm2; // Loop counters move only by increment and clear
    wordT rk2;
    wordT rn2;
    wordT c1;
    wordT c2;
    wordT c3;

    always_comb begin
        case (busSel)
            BUS_AR:  bus = ar;
            BUS_DR:  bus = dr;
            BUS_RP:  bus = rp;
            BUS_RT:  bus = rt;
            BUS_RM1: bus = rm1;
            BUS_RK1: bus = rk1;
            BUS_RN1: bus = rn1;
            BUS_RM2: bus = rm2;
            BUS_RK2: bus = rk2;
            BUS_RN2: bus = rn2;
            BUS_C1:  bus = c1;
            BUS_C2:  bus = c2;
            BUS_C3:  bus = c3;
            BUS_AC:  bus = ac;
            default: bus = memRData;
        endcase
    end

    // Both comparator inputs follow the same select
    always_comb begin
        case (cmpSel)
            CMP_K: begin
                cmpA1 = rk1;
                cmpA2 = rk2;
            end
            CMP_N: begin
                cmpA1 = rn1;
                cmpA2 = rn2;
            end
            default: begin
                cmpA1 = rm1;
                cmpA2 = rm2;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc  <= pcT'(`MMCORE_RESET_PC);
            ir  <= '0;
            ar  <= '0;
            dr  <= '0;
            rp  <= '0;
            rt  <= '0;
            rm1 <= '0;
            rk1 <= '0;
            rn1 <= '0;
            rm2 <= '0;
            rk2 <= '0;
            rn2 <= '0;
            c1  <= '0;
            c2  <= '0;
            c3  <= '0;
            ac  <= '0;
        end else begin
            if (inc.pc) pc <= pc + 1'b1;
            else if (regEn.pc) pc <= pcT'(bus); // Jump target via AR
            if (regEn.ir) ir <= iromData;
            if (regEn.ar) ar <= selAr ? iromData : bus;
            if (regEn.dr) dr <= bus;
            if (regEn.rp) rp <= bus;
            if (clr.rt) rt <= '0;
            else if (regEn.rt) rt <= bus;
            if (regEn.rm1) rm1 <= bus;
            if (regEn.rk1) rk1 <= bus;
            if (regEn.rn1) rn1 <= bus;
            if (clr.rm2) rm2 <= '0;
            else if (inc.rm2) rm2 <= rm2 + 1'b1;
            if (clr.rk2) rk2 <= '0;
            else if (inc.rk2) rk2 <= rk2 + 1'b1;
            if (clr.rn2) rn2 <= '0;
            else if (inc.rn2) rn2 <= rn2 + 1'b1;
            if (regEn.c1) c1 <= bus;
            if (inc.c2) c2 <= c2 + 1'b1;
            else if (regEn.c2) c2 <= bus;
            if (inc.c3) c3 <= c3 + 1'b1;
            else if (regEn.c3) c3 <= bus;
            if (clr.ac) ac <= '0;
            else if (regEn.ac) ac <= aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== src/mmcore_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmcore_top (
    input  logic              Clk,
    input  logic              arstN,
    input  mmcore_pkg::wordT  iromData,
    input  mmcore_pkg::wordT  memRData,
    output mmcore_pkg::pcT    iromAddr,
    output logic              iromRead,
    output logic              memRead,
    output logic              memWrite,
    output logic              done,
    output mmcore_pkg::wordT  memAddr,
    output mmcore_pkg::wordT  memWData
);
    import mmcore_pkg::*;

    regEnT  regEn;
    incT    inc;
    clrT    clr;
    busSrcT busSel;
    aluOpT  aluOp;
    cmpSelT cmpSel;
    logic   selAr;
    logic   zero;
    wordT   ir;
    wordT   ac;
    wordT   bus;
    wordT   cmpA1;
    wordT   cmpA2;
    wordT   aluResult;

    mmcore_ctrl i_ctrl (
        .Clk, .arstN, .zero, .ir,
        .iromRead, .memRead, .memWrite, .done, .selAr,
        .regEn, .inc, .clr, .busSel, .aluOp, .cmpSel
    );

    // PC, AR and DR drive the ROM and memory ports directly
    mmcore_regs i_regs (
        .Clk, .arstN, .selAr, .regEn, .inc, .clr, .busSel,
        .iromData, .memRData, .aluResult,
        .pc(iromAddr), .ir, .ar(memAddr), .dr(memWData), .ac, .bus,
        .cmpA1, .cmpA2, .cmpSel
    );

    mmcore_alu i_alu (
        .aluOp, .bus, .ac, .cmpA1, .cmpA2, .aluResult, .zero
    );

endmodule

`default_nettype wire

// ==== tb/mmcore_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmcore_chk (
    input logic             Clk,
    input logic             arstN,
    input logic             memRead,
    input logic             memWrite,
    input logic             done,
    input mmcore_pkg::wordT memAddr,
    input mmcore_pkg::wordT memWData
);

    // One memory access per state
    assert property (@(posedge Clk) disable iff (!arstN) !(memRead && memWrite))
        else $error("memRead and memWrite are high in the same cycle");

    assert property (@(posedge Clk) disable iff (!arstN) done |=> done)
        else $error("done fell without a reset");

    // Store address and data must be known
    assert property (@(posedge Clk) disable iff (!arstN)
                     memWrite |-> !$isunknown({memAddr, memWData}))
        else $error("memAddr or memWData unknown during a store");

endmodule

bind mmcore_top mmcore_chk i_chk (
    .Clk, .arstN, .memRead, .memWrite, .done, .memAddr, .memWData
);

`default_nettype wire

// ==== tb/mmcore_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mmcore_config.svh"

module mmcore_tb;
    import mmcore_pkg::*;

    localparam int ROM_DEPTH = 1 << `MMCORE_PC_W;
    localparam int MEM_DEPTH = 1 << `MMCORE_WORD_W;

    logic Clk;
    logic arstN;
    wordT iromData;
    wordT memRData;
    pcT   iromAddr;
    logic iromRead;
    logic memRead;
    logic memWrite;
    logic done;
    wordT memAddr;
    wordT memWData;

    wordT rom [ROM_DEPTH];
    wordT mem [MEM_DEPTH];
    logic iromReadQ; // Read requests seen one cycle back
    pcT   iromAddrQ;
    logic memReadQ;
    wordT memAddrQ;
    wordT expAddr[$];
    wordT expData[$];
    int   storeCount;
    int   errors;

    mmcore_top i_dut (
        .Clk, .arstN, .iromData, .memRData, .iromAddr, .iromRead,
        .memRead, .memWrite, .done, .memAddr, .memWData
    );

    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // ROM and memory answer one cycle after the read strobe
    task automatic serveMemories();
        if (iromReadQ) iromData = rom[iromAddrQ];
        if (memReadQ) memRData = mem[memAddrQ];
        iromReadQ = iromRead;
        iromAddrQ = iromAddr;
        memReadQ  = memRead;
        memAddrQ  = memAddr;
        if (arstN && memWrite) begin
            mem[memAddr] = memWData;
            if (storeCount < expAddr.size()) begin
                checkWord("memAddr", memAddr, expAddr[storeCount]);
                checkWord("memWData", memWData, expData[storeCount]);
            end else begin
                $display("A store to address %h at %0t ns was not expected", memAddr, $time);
                errors++;
            end
            storeCount++;
        end
    endtask

    task automatic nextCycle();
        @(negedge Clk);
        serveMemories();
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        repeat (5) nextCycle();
        arstN = 1'b1;
        // Core sits in FETCH_1 right after release
        checkFlag("iromRead", iromRead, 1'b1);
        checkWord("iromAddr", iromAddr, 8'h00);
        checkFlag("memRead", memRead, 1'b0);
        checkFlag("memWrite", memWrite, 1'b0);
        checkFlag("done", done, 1'b0);
    endtask

    initial begin
        int fd;
        int rc;
        int nProg;
        int nMem;
        int nExp;
        int nInstr;
        int addr;
        int val;
        int limit;
        int cycles;
        int testNum;
        int errBefore;
        string line;
        arstN     = 1'b0;
        iromData  = '0;
        memRData  = '0;
        iromReadQ = 1'b0;
        iromAddrQ = '0;
        memReadQ  = 1'b0;
        memAddrQ  = '0;
        storeCount = 0;
        errors    = 0;
        testNum   = 0;
        fd = $fopen("tb/mmcore_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/mmcore_testdata.txt");
            $display("Errors found");
            $finish;
        end else begin
            rc = $fgets(line, fd); // Two header lines
            rc = $fgets(line, fd);
            rc = $fscanf(fd, "%d %d %d %d", nProg, nMem, nExp, nInstr);
            while (rc == 4) begin
                errBefore = errors;
                for (int a = 0; a < ROM_DEPTH; a++) begin
                    rom[a] = 8'hF0 | wordT'((a ^ (a >> 4)) & 'hF); // Unused bytes decode as END
                end
                for (int a = 0; a < MEM_DEPTH; a++) begin
                    mem[a] = wordT'(a) ^ 8'hA5;
                end
                for (int i = 0; i < nProg; i++) begin
                    rc = $fscanf(fd, "%h", val);
                    rom[i] = wordT'(val);
                end
                for (int i = 0; i < nMem; i++) begin
                    rc = $fscanf(fd, "%h", val);
                    mem[i] = wordT'(val);
                end
                expAddr.delete();
                expData.delete();
                for (int i = 0; i < nExp; i++) begin
                    rc = $fscanf(fd, "%h %h", addr, val);
                    expAddr.push_back(wordT'(addr));
                    expData.push_back(wordT'(val));
                end
                storeCount = 0;
                applyReset();

                limit  = 8 * nInstr + 20;
                cycles = 0;
                while (!done && cycles < limit) begin
                    nextCycle();
                    cycles++;
                end
                if (!done) begin
                    $display("Test %0d timed out after %0d cycles without done", testNum, limit);
                    $display("Errors found");
                    $finish;
                end

                // Parked in ENDOP with all strobes quiet
                repeat (5) begin
                    nextCycle();
                    checkFlag("done", done, 1'b1);
                    checkFlag("iromRead", iromRead, 1'b0);
                    checkFlag("memRead", memRead, 1'b0);
                    checkFlag("memWrite", memWrite, 1'b0);
                end
                if (storeCount != nExp) begin
                    $display("Test %0d made %0d stores where %0d were expected",
                             testNum, storeCount, nExp);
                    errors++;
                end
                $display("Test %0d: %0d cycles, %0d stores, %0d errors",
                         testNum, cycles, storeCount, errors - errBefore);
                testNum++;
                rc = $fscanf(fd, "%d %d %d %d", nProg, nMem, nExp, nInstr);
            end
            $fclose(fd);
            $display("%0d tests run, %0d errors", testNum, errors);
            if (errors == 0 && testNum > 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/mmcore_testdata.txt ====
# Per test: program length, memory length, store count, instruction count (decimal);
# then program bytes, memory words from address 0, expected stores as address value (hex)
24 4 3 21
51 02 50 00 52 10 30 81 71 40 31 81 72 80 70 B1 71 40 62 61 60 B1 40 F0
11 22 33 44
10 11  11 33  12 00
33 4 3 28
52 20 50 00 30 81 71 A0 71 40 50 01 30 81 70 50 02 30 81 90 71 B1 40
20 03 A1 B2 B2 A2 71 B1 40 F0
C8 64 13 11
20 90  21 6C  22 7F
39 32 4 138
20 00 21 01 22 02 50 00 51 10 52 40 60 61 62 80 71 31 81 70 B0 31 81 90 A0 71 B0 B3
11 11 40 B1 B4 12 0E B2 10 0D F0
02 02 02 00 00 00 00 00 00 00 00 00 00 00 00 00
03 05 07 02 10 10 11 02 20 09 01 01 FF FF 02 80
40 1D  41 22  42 21  43 01
5 0 0 4
00 00 10 40 F0
